// ==== src/alu_pkg.sv ====
package alu_pkg;

  localparam int XLEN      = 64;
  localparam int WLEN      = 32;
  localparam int ALU_SEL_W = 34;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [WLEN-1:0]      word_t;
  typedef logic [ALU_SEL_W-1:0] alu_sel_t;

  // one-hot select bit positions
  localparam int OP_ADD    = 0;
  localparam int OP_ADDW   = 1;
  localparam int OP_SUB    = 2;
  localparam int OP_SUBW   = 3;
  localparam int OP_SLT    = 4;
  localparam int OP_SLTU   = 5;
  localparam int OP_AND    = 6;
  localparam int OP_OR     = 7;
  localparam int OP_XOR    = 8;
  // shift groups: 64-bit reg, 64-bit imm, word imm, word reg
  localparam int OP_SLL    = 9;
  localparam int OP_SLLI   = 10;
  localparam int OP_SLLIW  = 11;
  localparam int OP_SLLW   = 12;
  localparam int OP_SRL    = 13;
  localparam int OP_SRLI   = 14;
  localparam int OP_SRLIW  = 15;
  localparam int OP_SRLW   = 16;
  localparam int OP_SRA    = 17;
  localparam int OP_SRAI   = 18;
  localparam int OP_SRAIW  = 19;
  localparam int OP_SRAW   = 20;
  localparam int OP_REM    = 21;
  localparam int OP_REMU   = 22;
  localparam int OP_REMUW  = 23;
  localparam int OP_REMW   = 24;
  localparam int OP_DIV    = 25;
  localparam int OP_DIVU   = 26;
  localparam int OP_DIVUW  = 27;
  localparam int OP_DIVW   = 28;
  localparam int OP_MUL    = 29;
  localparam int OP_MULH   = 30;
  localparam int OP_MULHSU = 31;
  localparam int OP_MULHU  = 32;
  localparam int OP_MULW   = 33;

  typedef enum logic [1:0] {
    LOGIC_NONE,
    LOGIC_AND,
    LOGIC_OR,
    LOGIC_XOR
  } logic_fn_e;

  typedef struct packed {
    logic      subtract;
    logic      word;
    logic      slt;
    logic      sltu;
    logic_fn_e logic_fn;
  } arith_op_t;

  typedef struct packed {
    logic left;
    logic arith;
    logic word;
    logic wide_amount;
  } shift_op_t;

  typedef struct packed {
    logic rem;
    logic unsigned_op;
    logic word;
  } div_op_t;

  typedef enum logic [2:0] {
    MUL_MUL,
    MUL_MULH,
    MUL_MULHSU,
    MUL_MULHU,
    MUL_MULW
  } mul_kind_e;

  typedef enum logic [2:0] {
    RES_ARITH,
    RES_SHIFT,
    RES_DIV,
    RES_MUL,
    RES_ZERO
  } res_sel_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_DONE
  } mul_state_e;

endpackage

// ==== src/alu_arith_logic.sv ====
`timescale 1ns/1ps

module alu_arith_logic (
  input  alu_pkg::xlen_t     op_1,
  input  alu_pkg::xlen_t     op_2,
  input  alu_pkg::arith_op_t arith_op,
  output alu_pkg::xlen_t     arith_res
);
  import alu_pkg::*;

  xlen_t op_2_in;
  xlen_t sum;
  xlen_t logic_res;
  logic  lt_signed;
  logic  lt_unsigned;

  // single adder, subtract as op_1 + ~op_2 + 1
  assign op_2_in = op_2 ^ {XLEN{arith_op.subtract}};
  assign sum     = op_1 + op_2_in + xlen_t'(arith_op.subtract);

  // compare from operand signs and the difference sign
  assign lt_signed   = (op_1[XLEN-1] & ~op_2[XLEN-1]) |
                       ((op_1[XLEN-1] == op_2[XLEN-1]) & sum[XLEN-1]);
  assign lt_unsigned = (~op_1[XLEN-1] & op_2[XLEN-1]) |
                       ((op_1[XLEN-1] == op_2[XLEN-1]) & sum[XLEN-1]);

  always_comb begin
    case (arith_op.logic_fn)
      LOGIC_AND: logic_res = op_1 & op_2;
      LOGIC_OR:  logic_res = op_1 | op_2;
      LOGIC_XOR: logic_res = op_1 ^ op_2;
      default:   logic_res = '0;
    endcase
  end

  always_comb begin
    if (arith_op.slt) begin
      arith_res = xlen_t'(lt_signed);
    end else if (arith_op.sltu) begin
      arith_res = xlen_t'(lt_unsigned);
    end else if (arith_op.logic_fn != LOGIC_NONE) begin
      arith_res = logic_res;
    end else if (arith_op.word) begin
      // low word only, extension happens in the control block
      arith_res = {{(XLEN-WLEN){1'b0}}, sum[WLEN-1:0]};
    end else begin
      arith_res = sum;
    end
  end

endmodule

// ==== src/alu_shifter.sv ====
`timescale 1ns/1ps

module alu_shifter (
  input  alu_pkg::xlen_t     op_1,
  input  alu_pkg::xlen_t     op_2,
  input  alu_pkg::shift_op_t shift_op,
  output alu_pkg::xlen_t     shift_res
);
  import alu_pkg::*;

  logic [5:0] shamt;
  xlen_t      ushift_in;
  xlen_t      sshift_in;
  xlen_t      sll_res;
  xlen_t      srl_res;
  xlen_t      sra_res;

  // bit 5 of the amount only counts for 64-bit forms
  assign shamt = {shift_op.wide_amount & op_2[5], op_2[4:0]};

  // word right shifts see only the low word of op_1
  assign ushift_in = shift_op.word ? {{(XLEN-WLEN){1'b0}}, op_1[WLEN-1:0]} : op_1;
  assign sshift_in = shift_op.word ? {{(XLEN-WLEN){op_1[WLEN-1]}}, op_1[WLEN-1:0]} : op_1;

  assign sll_res = op_1 << shamt;
  assign srl_res = ushift_in >> shamt;
  assign sra_res = $signed(sshift_in) >>> shamt;

  always_comb begin
    if (shift_op.left) begin
      shift_res = sll_res;
    end else if (shift_op.arith) begin
      shift_res = sra_res;
    end else begin
      shift_res = srl_res;
    end
  end

endmodule

// ==== src/alu_divider.sv ====
`timescale 1ns/1ps

module alu_divider (
  input  alu_pkg::xlen_t   op_1,
  input  alu_pkg::xlen_t   op_2,
  input  alu_pkg::div_op_t div_op,
  output alu_pkg::xlen_t   div_res
);
  import alu_pkg::*;

  word_t op_1_lo;
  word_t op_2_lo;
  xlen_t dividend;
  xlen_t divisor;
  xlen_t divisor_safe;
  xlen_t min_val;
  logic  div_zero;
  logic  overflow;
  xlen_t quot_s;
  xlen_t quot_u;
  xlen_t rem_s;
  xlen_t rem_u;
  xlen_t quot;
  xlen_t remain;
  xlen_t res_full;

  assign op_1_lo = op_1[WLEN-1:0];
  assign op_2_lo = op_2[WLEN-1:0];

  // word forms run through the same 64-bit divider on extended operands
  always_comb begin
    if (!div_op.word) begin
      dividend = op_1;
      divisor  = op_2;
      min_val  = {1'b1, {(XLEN-1){1'b0}}};
    end else if (div_op.unsigned_op) begin
      dividend = {{(XLEN-WLEN){1'b0}}, op_1_lo};
      divisor  = {{(XLEN-WLEN){1'b0}}, op_2_lo};
      min_val  = {1'b1, {(XLEN-1){1'b0}}};
    end else begin
      dividend = {{(XLEN-WLEN){op_1_lo[WLEN-1]}}, op_1_lo};
      divisor  = {{(XLEN-WLEN){op_2_lo[WLEN-1]}}, op_2_lo};
      min_val  = {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}};
    end
  end

  assign div_zero = (divisor == '0);
  assign overflow = !div_op.unsigned_op && (divisor == '1) && (dividend == min_val);

  // corner cases never reach the divide operators
  assign divisor_safe = (div_zero || overflow) ? xlen_t'(1) : divisor;

  assign quot_s = $signed(dividend) / $signed(divisor_safe);
  assign rem_s  = $signed(dividend) % $signed(divisor_safe);
  assign quot_u = dividend / divisor_safe;
  assign rem_u  = dividend % divisor_safe;

  always_comb begin
    if (div_zero) begin
      quot   = '1;
      remain = dividend;
    end else if (overflow) begin
      quot   = dividend;
      remain = '0;
    end else begin
      quot   = div_op.unsigned_op ? quot_u : quot_s;
      remain = div_op.unsigned_op ? rem_u : rem_s;
    end
  end

  assign res_full = div_op.rem ? remain : quot;
  assign div_res  = div_op.word ?
                    {{(XLEN-WLEN){res_full[WLEN-1]}}, res_full[WLEN-1:0]} : res_full;

endmodule

// ==== src/alu_multiplier.sv ====
`timescale 1ns/1ps

module alu_multiplier #(
  parameter int WIDTH = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               mul_start,
  input  alu_pkg::mul_kind_e mul_kind,
  input  alu_pkg::xlen_t     multiplicand,
  input  alu_pkg::xlen_t     multiplier,
  output logic               mul_done,
  output alu_pkg::xlen_t     mul_result
);
  import alu_pkg::*;

  localparam int CNT_W = $clog2(WIDTH);
  localparam int HALF  = WIDTH / 2;

  logic [WIDTH-1:0]   mcand_in;
  logic [WIDTH-1:0]   mplier_in;
  logic               mcand_neg;
  logic               mplier_neg;
  mul_state_e         state;
  logic [CNT_W-1:0]   cnt;
  mul_kind_e          kind_q;
  logic               neg_q;
  logic [WIDTH-1:0]   mcand_q;
  logic [2*WIDTH-1:0] acc;
  logic [WIDTH:0]     partial;
  logic [2*WIDTH-1:0] product;
  logic [WIDTH-1:0]   pick;

  assign mcand_in  = multiplicand[WIDTH-1:0];
  assign mplier_in = multiplier[WIDTH-1:0];

  // mulh treats both operands as signed, mulhsu only the first
  assign mcand_neg  = mcand_in[WIDTH-1] & ((mul_kind == MUL_MULH) || (mul_kind == MUL_MULHSU));
  assign mplier_neg = mplier_in[WIDTH-1] & (mul_kind == MUL_MULH);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (mul_start) begin
            state <= ST_BUSY;
            cnt   <= '0;
          end
        end
        ST_BUSY: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(WIDTH - 1)) begin
            state <= ST_DONE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // add the multiplicand into the upper half when the lsb is set
  assign partial = {1'b0, acc[2*WIDTH-1:WIDTH]} + (acc[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge clk) begin
    if (mul_start && state == ST_IDLE) begin
      mcand_q <= mcand_neg ? -mcand_in : mcand_in;
      acc     <= {{WIDTH{1'b0}}, (mplier_neg ? -mplier_in : mplier_in)};
      neg_q   <= mcand_neg ^ mplier_neg;
      kind_q  <= mul_kind;
    end else if (state == ST_BUSY) begin
      acc <= {partial, acc[WIDTH-1:1]};
    end
  end

  // sign fix and half select, stable until the next start
  assign product = neg_q ? -acc : acc;

  always_comb begin
    case (kind_q)
      MUL_MUL:  pick = product[WIDTH-1:0];
      MUL_MULW: pick = {{(WIDTH-HALF){product[HALF-1]}}, product[HALF-1:0]};
      default:  pick = product[2*WIDTH-1:WIDTH];
    endcase
  end

  assign mul_result = xlen_t'(pick);
  assign mul_done   = (state == ST_DONE);

endmodule

// ==== src/alu_ctrl.sv ====
`timescale 1ns/1ps

module alu_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  alu_pkg::alu_sel_t  alu_sel,
  input  logic               lsu_stall,
  input  alu_pkg::xlen_t     arith_res,
  input  alu_pkg::xlen_t     shift_res,
  input  alu_pkg::xlen_t     div_res,
  input  alu_pkg::xlen_t     mul_result,
  input  logic               mul_done,
  output alu_pkg::arith_op_t arith_op,
  output alu_pkg::shift_op_t shift_op,
  output alu_pkg::div_op_t   div_op,
  output alu_pkg::mul_kind_e mul_kind,
  output logic               mul_start,
  output logic               alu_stall,
  output logic               alu_ok,
  output alu_pkg::xlen_t     result
);
  import alu_pkg::*;

  logic       is_arith;
  logic       is_shift;
  logic       is_div;
  logic       is_mul;
  res_sel_e   res_sel;
  mul_state_e state;
  mul_state_e state_next;

  assign is_arith = |alu_sel[OP_XOR:OP_ADD];
  assign is_shift = |alu_sel[OP_SRAW:OP_SLL];
  assign is_div   = |alu_sel[OP_DIVW:OP_REM];
  assign is_mul   = |alu_sel[OP_MULW:OP_MUL];

  // select bits to per-unit op fields
  always_comb begin
    arith_op.subtract = alu_sel[OP_SUB] | alu_sel[OP_SUBW] | alu_sel[OP_SLT] | alu_sel[OP_SLTU];
    arith_op.word     = alu_sel[OP_ADDW] | alu_sel[OP_SUBW];
    arith_op.slt      = alu_sel[OP_SLT];
    arith_op.sltu     = alu_sel[OP_SLTU];
    if (alu_sel[OP_AND])      arith_op.logic_fn = LOGIC_AND;
    else if (alu_sel[OP_OR])  arith_op.logic_fn = LOGIC_OR;
    else if (alu_sel[OP_XOR]) arith_op.logic_fn = LOGIC_XOR;
    else                      arith_op.logic_fn = LOGIC_NONE;

    shift_op.left  = |alu_sel[OP_SLLW:OP_SLL];
    shift_op.arith = |alu_sel[OP_SRAW:OP_SRA];
    shift_op.word  = alu_sel[OP_SLLIW] | alu_sel[OP_SLLW] | alu_sel[OP_SRLIW] |
                     alu_sel[OP_SRLW] | alu_sel[OP_SRAIW] | alu_sel[OP_SRAW];
    // 64-bit forms may use shamt[5]
    shift_op.wide_amount = alu_sel[OP_SLL] | alu_sel[OP_SLLI] | alu_sel[OP_SRL] |
                           alu_sel[OP_SRLI] | alu_sel[OP_SRA] | alu_sel[OP_SRAI];

    div_op.rem         = |alu_sel[OP_REMW:OP_REM];
    div_op.unsigned_op = alu_sel[OP_REMU] | alu_sel[OP_REMUW] | alu_sel[OP_DIVU] |
                         alu_sel[OP_DIVUW];
    div_op.word        = alu_sel[OP_REMUW] | alu_sel[OP_REMW] | alu_sel[OP_DIVUW] |
                         alu_sel[OP_DIVW];

    if (alu_sel[OP_MULH])        mul_kind = MUL_MULH;
    else if (alu_sel[OP_MULHSU]) mul_kind = MUL_MULHSU;
    else if (alu_sel[OP_MULHU])  mul_kind = MUL_MULHU;
    else if (alu_sel[OP_MULW])   mul_kind = MUL_MULW;
    else                         mul_kind = MUL_MUL;

    if (is_arith)      res_sel = RES_ARITH;
    else if (is_shift) res_sel = RES_SHIFT;
    else if (is_div)   res_sel = RES_DIV;
    else if (is_mul)   res_sel = RES_MUL;
    else               res_sel = RES_ZERO;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // multiply sequencing, stall is raised in the issue cycle already
  always_comb begin
    state_next = state;
    mul_start  = 1'b0;
    alu_stall  = 1'b0;
    alu_ok     = 1'b0;
    case (state)
      ST_IDLE: begin
        if (is_mul) begin
          mul_start  = 1'b1;
          alu_stall  = 1'b1;
          state_next = ST_BUSY;
        end
      end
      ST_BUSY: begin
        alu_stall = 1'b1;
        if (mul_done) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // hold the product while the lsu is stalled
        if (lsu_stall) begin
          alu_stall = 1'b1;
        end else begin
          alu_ok     = 1'b1;
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_comb begin
    case (res_sel)
      RES_ARITH: result = arith_op.word ?
                          {{(XLEN-WLEN){arith_res[WLEN-1]}}, arith_res[WLEN-1:0]} : arith_res;
      RES_SHIFT: result = shift_op.word ?
                          {{(XLEN-WLEN){shift_res[WLEN-1]}}, shift_res[WLEN-1:0]} : shift_res;
      RES_DIV:   result = div_res;
      RES_MUL:   result = mul_result;
      default:   result = '0;
    endcase
  end

endmodule

// ==== src/alu_top.sv ====
`timescale 1ns/1ps

module alu_top (
  input  logic              clk,
  input  logic              reset,
  input  alu_pkg::xlen_t    op_1,
  input  alu_pkg::xlen_t    op_2,
  input  alu_pkg::alu_sel_t alu_sel,
  input  logic              lsu_stall,
  output logic              alu_stall,
  output logic              alu_ok,
  output alu_pkg::xlen_t    result
);
  import alu_pkg::*;

  arith_op_t arith_op;
  shift_op_t shift_op;
  div_op_t   div_op;
  mul_kind_e mul_kind;
  logic      mul_start;
  logic      mul_done;
  xlen_t     arith_res;
  xlen_t     shift_res;
  xlen_t     div_res;
  xlen_t     mul_result;

  alu_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .alu_sel    (alu_sel),
    .lsu_stall  (lsu_stall),
    .arith_res  (arith_res),
    .shift_res  (shift_res),
    .div_res    (div_res),
    .mul_result (mul_result),
    .mul_done   (mul_done),
    .arith_op   (arith_op),
    .shift_op   (shift_op),
    .div_op     (div_op),
    .mul_kind   (mul_kind),
    .mul_start  (mul_start),
    .alu_stall  (alu_stall),
    .alu_ok     (alu_ok),
    .result     (result)
  );

  alu_arith_logic u_arith_logic (
    .op_1      (op_1),
    .op_2      (op_2),
    .arith_op  (arith_op),
    .arith_res (arith_res)
  );

  alu_shifter u_shifter (
    .op_1      (op_1),
    .op_2      (op_2),
    .shift_op  (shift_op),
    .shift_res (shift_res)
  );

  alu_divider u_divider (
    .op_1    (op_1),
    .op_2    (op_2),
    .div_op  (div_op),
    .div_res (div_res)
  );

  alu_multiplier #(
    .WIDTH (XLEN)
  ) u_multiplier (
    .clk          (clk),
    .reset        (reset),
    .mul_start    (mul_start),
    .mul_kind     (mul_kind),
    .multiplicand (op_1),
    .multiplier   (op_2),
    .mul_done     (mul_done),
    .mul_result   (mul_result)
  );

endmodule

// ==== dv/alu_props.sv ====
`timescale 1ns/1ps

module alu_props (
  input logic                clk,
  input logic                reset,
  input logic                lsu_stall,
  input logic                alu_stall,
  input logic                alu_ok,
  input alu_pkg::mul_state_e state
);
  import alu_pkg::*;

  ok_not_with_stall: assert property (@(posedge clk) disable iff (reset)
    !(alu_ok && alu_stall))
    else $error("alu_ok and alu_stall are high together");

  // ok is a single pulse
  ok_one_cycle: assert property (@(posedge clk) disable iff (reset)
    alu_ok |=> !alu_ok)
    else $error("alu_ok stayed high for more than one cycle");

  done_held_on_lsu_stall: assert property (@(posedge clk) disable iff (reset)
    (state == ST_DONE && lsu_stall) |=> (state == ST_DONE))
    else $error("multiply left the done state while lsu_stall was high");

  quiet_after_reset: assert property (@(posedge clk)
    reset |=> (!alu_stall && !alu_ok))
    else $error("alu_stall or alu_ok high in the cycle after reset");

endmodule

bind alu_ctrl alu_props u_props (
  .clk       (clk),
  .reset     (reset),
  .lsu_stall (lsu_stall),
  .alu_stall (alu_stall),
  .alu_ok    (alu_ok),
  .state     (state)
);

// ==== dv/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb;
  import alu_pkg::*;

  localparam int    CLK_PERIOD      = 8;
  localparam int    SETTLE          = 2;
  localparam int    RESET_CYCLES    = 5;
  localparam int    NUM_PATTERNS    = 45;
  localparam int    WORDS_PER_REC   = 5;
  localparam int    SEED            = 71783;
  localparam int    WATCHDOG_CYCLES = NUM_PATTERNS * 100 + RESET_CYCLES;
  // 65 cycles start to done, plus the issue cycle, then ok in the done state
  localparam int    MUL_OK_CYCLE    = 66;
  localparam string PATTERN_FILE    = "dv/alu_patterns.hex";

  logic     clk;
  logic     reset;
  xlen_t    op_1;
  xlen_t    op_2;
  alu_sel_t alu_sel;
  logic     lsu_stall;
  logic     alu_stall;
  logic     alu_ok;
  xlen_t    result;

  logic [63:0] pat_mem [0:NUM_PATTERNS*WORDS_PER_REC-1];

  int unsigned rng_state;
  int          checks;
  int          errors;
  int          i;
  int          idx;
  int          base;
  int          gap;
  logic        prev_mul;
  logic        this_mul;
  string       name;

  alu_top DUT (
    .clk       (clk),
    .reset     (reset),
    .op_1      (op_1),
    .op_2      (op_2),
    .alu_sel   (alu_sel),
    .lsu_stall (lsu_stall),
    .alu_stall (alu_stall),
    .alu_ok    (alu_ok),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  function automatic alu_sel_t one_hot(input int sel_idx);
    alu_sel_t sel;
    sel = '0;
    // indices past the select width leave it all zero
    if (sel_idx >= 0 && sel_idx < ALU_SEL_W) sel[sel_idx] = 1'b1;
    return sel;
  endfunction

  function automatic logic is_mul_index(input int sel_idx);
    return (sel_idx >= OP_MUL) && (sel_idx <= OP_MULW);
  endfunction

  task automatic compare(input string test, input xlen_t expected, input xlen_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", test, expected, actual);
    end
  endtask

  task automatic idle_gap(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      alu_sel   = '0;
      lsu_stall = 1'b0;
      #(SETTLE);
      compare("idle result", '0, result);
      compare("idle stall", '0, xlen_t'(alu_stall));
      compare("idle ok", '0, xlen_t'(alu_ok));
    end
  endtask

  task automatic run_comb(input string test, input int sel_idx, input xlen_t a,
                          input xlen_t b, input xlen_t expected);
    @(negedge clk);
    op_1      = a;
    op_2      = b;
    alu_sel   = one_hot(sel_idx);
    lsu_stall = 1'b0;
    #(SETTLE);
    compare(test, expected, result);
    compare({test, " stall"}, '0, xlen_t'(alu_stall));
    compare({test, " ok"}, '0, xlen_t'(alu_ok));
  endtask

  task automatic run_mul(input string test, input int sel_idx, input xlen_t a,
                         input xlen_t b, input int stall_n, input xlen_t expected);
    int cyc;
    int ok_cyc;
    @(negedge clk);
    op_1      = a;
    op_2      = b;
    alu_sel   = one_hot(sel_idx);
    lsu_stall = (stall_n > 0);
    #(SETTLE);
    compare({test, " stall at issue"}, xlen_t'(1), xlen_t'(alu_stall));
    compare({test, " ok at issue"}, '0, xlen_t'(alu_ok));
    cyc    = 0;
    ok_cyc = (stall_n > MUL_OK_CYCLE) ? stall_n : MUL_OK_CYCLE;
    while (alu_ok !== 1'b1) begin
      @(negedge clk);
      cyc++;
      lsu_stall = (cyc < stall_n);
      #(SETTLE);
      if (alu_ok !== 1'b1) begin
        compare({test, " stall before ok"}, xlen_t'(1), xlen_t'(alu_stall));
        // product waits in the done state while the lsu is stalled
        if (cyc >= MUL_OK_CYCLE) compare({test, " held product"}, expected, result);
      end
    end
    compare({test, " ok cycle"}, xlen_t'(ok_cyc), xlen_t'(cyc));
    compare({test, " stall with ok"}, '0, xlen_t'(alu_stall));
    compare(test, expected, result);
  endtask

  initial begin
    reset     = 1'b1;
    op_1      = '0;
    op_2      = '0;
    alu_sel   = '0;
    lsu_stall = 1'b0;
    checks    = 0;
    errors    = 0;
    rng_state = SEED;
    prev_mul  = 1'b0;
    $readmemh(PATTERN_FILE, pat_mem);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    if ($isunknown(pat_mem[NUM_PATTERNS*WORDS_PER_REC-1]) ||
        pat_mem[NUM_PATTERNS*WORDS_PER_REC-1] == '0) begin
      errors++;
      $display("pattern file %s is missing or shorter than expected", PATTERN_FILE);
    end

    for (i = 0; i < NUM_PATTERNS; i++) begin
      base     = i * WORDS_PER_REC;
      idx      = int'(pat_mem[base][7:0]);
      this_mul = is_mul_index(idx);
      name     = $sformatf("pattern %0d (op %0d)", i, idx);
      // back-to-back multiplies issue right after alu_ok
      if (!(prev_mul && this_mul)) begin
        gap = int'((lcg_next() >> 16) % 4);
        idle_gap(gap);
      end
      if (this_mul) begin
        run_mul(name, idx, pat_mem[base+1], pat_mem[base+2], int'(pat_mem[base+3][7:0]),
                pat_mem[base+4]);
      end else begin
        run_comb(name, idx, pat_mem[base+1], pat_mem[base+2], pat_mem[base+4]);
      end
      prev_mul = this_mul;
    end

    idle_gap(1);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/alu_patterns.hex ====
// columns: op index, op_1, op_2, lsu_stall cycles, expected result
// op index 3F selects nothing
00 7FFFFFFFFFFFFFFF 0000000000000001 00 8000000000000000
01 000000007FFFFFFF 0000000000000001 00 FFFFFFFF80000000
02 0000000000000000 0000000000000001 00 FFFFFFFFFFFFFFFF
03 0000000180000000 0000000000000001 00 000000007FFFFFFF
04 8000000000000000 0000000000000001 00 0000000000000001
04 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFF 00 0000000000000001
05 8000000000000000 0000000000000001 00 0000000000000000
05 7FFFFFFFFFFFFFFF 8000000000000000 00 0000000000000001
06 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 00 F000F000F000F000
07 F0F0F0F0F0F0F0F0 0F0F0F0F0F0F0F0F 00 FFFFFFFFFFFFFFFF
08 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 00 0FF00FF00FF00FF0
09 0000000000000001 000000000000003F 00 8000000000000000
0A 0000000000000001 0000000000000020 00 0000000100000000
0B 0000000000000001 000000000000001F 00 FFFFFFFF80000000
0C 0000000000000003 0000000000000020 00 0000000000000003
0D 8000000000000000 000000000000003F 00 0000000000000001
0E FFFFFFFFFFFFFFFF 0000000000000000 00 FFFFFFFFFFFFFFFF
0F FFFFFFFF80000000 000000000000001F 00 0000000000000001
10 FFFFFFFF80000000 0000000000000004 00 0000000008000000
11 8000000000000000 000000000000003F 00 FFFFFFFFFFFFFFFF
12 8000000000000000 0000000000000020 00 FFFFFFFF80000000
13 0000000080000000 000000000000001F 00 FFFFFFFFFFFFFFFF
14 000000007FFFFFF0 0000000000000024 00 0000000007FFFFFF
15 FFFFFFFFFFFFFFF9 0000000000000002 00 FFFFFFFFFFFFFFFF
15 8000000000000000 0000000000000000 00 8000000000000000
16 0000000000000007 0000000000000000 00 0000000000000007
17 00000000FFFFFFFF 0000000000000010 00 000000000000000F
18 0000000080000000 00000000FFFFFFFF 00 0000000000000000
19 8000000000000000 FFFFFFFFFFFFFFFF 00 8000000000000000
19 0000000000000064 FFFFFFFFFFFFFFF9 00 FFFFFFFFFFFFFFF2
1A FFFFFFFFFFFFFFFF 0000000000000000 00 FFFFFFFFFFFFFFFF
1B 12345678FFFFFFFE 0000000000000002 00 000000007FFFFFFF
1C 00000000FFFFFFF9 0000000000000002 00 FFFFFFFFFFFFFFFD
1C 0000000080000000 00000000FFFFFFFF 00 FFFFFFFF80000000
1C 0000000012345678 0000000000000000 00 FFFFFFFFFFFFFFFF
3F 123456789ABCDEF0 0FEDCBA987654321 00 0000000000000000
1D FFFFFFFFFFFFFFFF 0000000000000005 00 FFFFFFFFFFFFFFFB
1E 8000000000000000 8000000000000000 00 4000000000000000
1E FFFFFFFFFFFFFFFE 4000000000000000 00 FFFFFFFFFFFFFFFF
1F FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 00 FFFFFFFFFFFFFFFF
1F 0000000000000002 8000000000000000 00 0000000000000001
20 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 00 FFFFFFFFFFFFFFFE
21 0000000000010000 0000000000008000 05 FFFFFFFF80000000
1D 0000000100000000 0000000000000003 46 0000000300000000
20 0000000200000000 0000000080000000 00 0000000000000001

// ==== filelist.f ====
src/alu_pkg.sv
src/alu_arith_logic.sv
src/alu_shifter.sv
src/alu_divider.sv
src/alu_multiplier.sv
src/alu_ctrl.sv
src/alu_top.sv
dv/alu_props.sv
dv/alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the ALU testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module alu_tb -Mdir obj_dir -o alu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/alu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
